// File: bench/bus_trace.txt
# req write a2 a1 a0 d2 d1 d0 grant ack_out rdata chk, one line per clock cycle
# req/write/grant/ack_out binary with bit 2 = master 2, addr and data hex, chk=1 compares rdata
000 000 0 0 0 00 00 00 000 000 00 1
000 000 0 0 0 00 00 00 000 000 00 1
000 000 0 0 0 00 00 00 000 000 00 1
111 001 7 3 3 00 00 5A 000 000 00 0
111 001 7 3 3 00 00 5A 001 000 00 0
111 001 7 3 3 00 00 5A 001 000 00 0
111 001 7 3 3 00 00 5A 001 000 00 0
110 001 7 3 3 00 00 5A 001 001 00 0
110 000 7 3 0 00 00 00 010 000 00 0
110 000 7 3 0 00 00 00 010 000 00 0
110 000 7 3 0 00 00 00 010 000 00 0
100 000 7 3 0 00 00 00 010 010 5A 1
100 000 7 0 0 00 00 00 100 000 00 0
101 000 7 0 3 00 00 00 100 000 00 0
101 000 7 0 3 00 00 00 100 000 00 0
001 000 7 0 3 00 00 00 100 100 00 1
001 000 0 0 3 00 00 00 001 000 00 0
001 000 0 0 3 00 00 00 001 000 00 0
001 000 0 0 3 00 00 00 001 000 00 0
001 000 0 0 3 00 00 00 001 001 5A 1
001 001 0 0 7 00 00 C3 001 000 00 0
001 001 0 0 7 00 00 C3 001 000 00 0
001 001 0 0 7 00 00 C3 001 000 00 0
001 001 0 0 7 00 00 C3 001 001 00 0
001 000 0 0 7 00 00 00 001 000 00 0
001 000 0 0 7 00 00 00 001 000 00 0
001 000 0 0 7 00 00 00 001 000 00 0
000 000 0 0 7 00 00 00 001 001 C3 1
000 000 0 0 0 00 00 00 000 000 00 0
110 100 F F 0 7E 00 00 000 000 00 0
110 100 F F 0 7E 00 00 010 000 00 0
110 100 F F 0 7E 00 00 010 000 00 0
110 100 F F 0 7E 00 00 010 000 00 0
100 100 F F 0 7E 00 00 010 010 00 1
100 100 F 0 0 7E 00 00 100 000 00 0
100 100 F 0 0 7E 00 00 100 000 00 0
100 100 F 0 0 7E 00 00 100 000 00 0
000 100 F 0 0 7E 00 00 100 100 00 0
000 000 0 0 0 00 00 00 000 000 00 0
000 000 0 0 0 00 00 00 000 000 00 1

// File: flist.f
hdl/bus_pkg.sv
hdl/bus_if.sv
hdl/bus_arbiter.sv
hdl/bus_master_mux.sv
hdl/bus_slave_mem.sv
hdl/bus_system.sv
bench/bus_arbiter_props.sv
bench/bus_system_tb.sv

// File: bench/bus_system_tb.sv
`timescale 1ns/10ps

module bus_system_tb;
    import bus_pkg::*;

    localparam int N_MASTERS     = DEF_N_MASTERS;
    localparam int ADDR_W        = DEF_ADDR_W;
    localparam int DATA_W        = DEF_DATA_W;
    localparam int ACK_DELAY     = DEF_ACK_DELAY;
    localparam int RESET_TIMEOUT = 20;
    localparam int IDLE_TIMEOUT  = 4 * (ACK_DELAY + 2);
    localparam int TRACE_LIMIT   = 1000;

    logic                        clk;
    logic                        reset;
    logic [N_MASTERS-1:0]        req;
    logic [N_MASTERS-1:0]        write;
    logic [N_MASTERS*ADDR_W-1:0] addr_in;
    logic [N_MASTERS*DATA_W-1:0] wdata_in;
    logic [N_MASTERS-1:0]        grant;
    logic [N_MASTERS-1:0]        ack_out;
    logic [DATA_W-1:0]           rdata_out;

    integer fd;
    integer code;
    integer n_fields;
    integer cycle_count;
    integer wait_cycles;
    string  line;

    // stimulus and expected outputs of one trace line.
    logic [N_MASTERS-1:0] t_req;
    logic [N_MASTERS-1:0] t_write;
    logic [ADDR_W-1:0]    t_a0;
    logic [ADDR_W-1:0]    t_a1;
    logic [ADDR_W-1:0]    t_a2;
    logic [DATA_W-1:0]    t_d0;
    logic [DATA_W-1:0]    t_d1;
    logic [DATA_W-1:0]    t_d2;
    logic [N_MASTERS-1:0] e_grant;
    logic [N_MASTERS-1:0] e_ack;
    logic [DATA_W-1:0]    e_rdata;
    logic                 e_chk;

    bus_system #(
        .N_MASTERS (N_MASTERS),
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .ACK_DELAY (ACK_DELAY)
    ) u_bus_system (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .write     (write),
        .addr_in   (addr_in),
        .wdata_in  (wdata_in),
        .grant     (grant),
        .ack_out   (ack_out),
        .rdata_out (rdata_out)
    );

    bind bus_arbiter bus_arbiter_props #(
        .N_MASTERS (N_MASTERS)
    ) u_arbiter_props (
        .clk     (clk),
        .reset   (reset),
        .bus_ack (bus_ack),
        .req     (req),
        .grant   (grant)
    );

    // ####################################################################
    // clock and reset
    // ####################################################################

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
    end

    // ####################################################################
    // helpers
    // ####################################################################

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // ####################################################################
    // trace replay
    // ####################################################################

    initial begin
        req      = '0;
        write    = '0;
        addr_in  = '0;
        wdata_in = '0;

        fd = $fopen("bench/bus_trace.txt", "r");
        if (fd == 0) begin
            $display("the trace file bench/bus_trace.txt could not be opened");
            stop_with_failure();
        end

        wait_cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                $display("reset was never released");
                stop_with_failure();
            end
        end

        cycle_count = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%b %b %h %h %h %h %h %h %b %b %h %b",
                               t_req, t_write, t_a2, t_a1, t_a0, t_d2, t_d1, t_d0,
                               e_grant, e_ack, e_rdata, e_chk);
            if (n_fields != 12) begin
                $display("trace line for cycle %0d could not be parsed", cycle_count);
                stop_with_failure();
            end
            if (cycle_count >= TRACE_LIMIT) begin
                $display("trace is longer than %0d cycles", TRACE_LIMIT);
                stop_with_failure();
            end

            @(posedge clk);
            #2;
            req      = t_req;
            write    = t_write;
            addr_in  = {t_a2, t_a1, t_a0};
            wdata_in = {t_d2, t_d1, t_d0};

            // sample just before the next edge.
            #35;
            check_value("grant", 32'(grant), 32'(e_grant));
            check_value("ack_out", 32'(ack_out), 32'(e_ack));
            if (e_chk) begin
                check_value("rdata_out", 32'(rdata_out), 32'(e_rdata));
            end
            check_value("arbiter assertion failures",
                        u_bus_system.u_arbiter.u_arbiter_props.fail_count, 32'd0);
            cycle_count++;
        end
        $fclose(fd);

        if (cycle_count == 0) begin
            $display("the trace file held no cycles");
            stop_with_failure();
        end

        // bus must drain before the run ends.
        wait_cycles = 0;
        while (grant !== '0 || ack_out !== '0) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > IDLE_TIMEOUT) begin
                $display("bus did not return to idle after the trace");
                stop_with_failure();
            end
        end

        // edges passed while draining are covered too.
        check_value("arbiter assertion failures",
                    u_bus_system.u_arbiter.u_arbiter_props.fail_count, 32'd0);

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: bench/bus_arbiter_props.sv
`timescale 1ns/10ps

module bus_arbiter_props #(
    parameter int N_MASTERS = bus_pkg::DEF_N_MASTERS
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 bus_ack,
    input logic [N_MASTERS-1:0] req,
    input logic [N_MASTERS-1:0] grant
);

    int fail_count = 0;

    // ####################################################################
    // grant rules
    // ####################################################################

    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant))
        else begin
            fail_count++;
            $error("more than one grant bit set");
        end

    // held grant only moves at the ack edge.
    grant_held: assert property (@(posedge clk) disable iff (reset)
        (grant != '0 && !bus_ack) |=> $stable(grant))
        else begin
            fail_count++;
            $error("grant changed without bus_ack");
        end

    for (genvar i = 0; i < N_MASTERS; i++) begin : g_rise
        localparam logic [N_MASTERS-1:0] LOWER = N_MASTERS'((1 << i) - 1);

        grant_rise: assert property (@(posedge clk) disable iff (reset)
            $rose(grant[i]) |-> $past(req[i] && ((req & LOWER) == '0)))
            else begin
                fail_count++;
                $error("grant bit %0d rose without winning request", i);
            end
    end

    grant_reset: assert property (@(posedge clk) $fell(reset) |-> (grant == '0))
        else begin
            fail_count++;
            $error("grant not clear after reset");
        end

endmodule

// File: hdl/bus_system.sv
`timescale 1ns/10ps

module bus_system #(
    parameter int N_MASTERS = bus_pkg::DEF_N_MASTERS,
    parameter int ADDR_W    = bus_pkg::DEF_ADDR_W,
    parameter int DATA_W    = bus_pkg::DEF_DATA_W,
    parameter int ACK_DELAY = bus_pkg::DEF_ACK_DELAY
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [N_MASTERS-1:0]        req,
    input  logic [N_MASTERS-1:0]        write,
    input  logic [N_MASTERS*ADDR_W-1:0] addr_in,
    input  logic [N_MASTERS*DATA_W-1:0] wdata_in,
    output logic [N_MASTERS-1:0]        grant,
    output logic [N_MASTERS-1:0]        ack_out,
    output logic [DATA_W-1:0]           rdata_out
);

    logic bus_ack;

    // ####################################################################
    // shared bus
    // ####################################################################

    bus_if #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_bus ();

    // slave ack also releases the arbiter.
    assign bus_ack = u_bus.ack;

    // ####################################################################
    // arbitration and master side
    // ####################################################################

    bus_arbiter #(
        .N_MASTERS (N_MASTERS)
    ) u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .bus_ack (bus_ack),
        .req     (req),
        .grant   (grant)
    );

    bus_master_mux #(
        .N_MASTERS (N_MASTERS),
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W)
    ) u_mux (
        .grant     (grant),
        .write     (write),
        .addr_in   (addr_in),
        .wdata_in  (wdata_in),
        .ack_out   (ack_out),
        .rdata_out (rdata_out),
        .bus       (u_bus.mux_mp)
    );

    // ####################################################################
    // memory slave
    // ####################################################################

    bus_slave_mem #(
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .ACK_DELAY (ACK_DELAY)
    ) u_mem (
        .clk   (clk),
        .reset (reset),
        .bus   (u_bus.mem_mp)
    );

endmodule

// File: hdl/bus_slave_mem.sv
`timescale 1ns/10ps

module bus_slave_mem #(
    parameter int ADDR_W    = bus_pkg::DEF_ADDR_W,
    parameter int DATA_W    = bus_pkg::DEF_DATA_W,
    parameter int ACK_DELAY = bus_pkg::DEF_ACK_DELAY
) (
    input  logic  clk,
    input  logic  reset,
    bus_if.mem_mp bus
);
    import bus_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;
    // counter holds at most ACK_DELAY-1.
    localparam int CNT_W = (ACK_DELAY > 1) ? $clog2(ACK_DELAY) : 1;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_DONE
    } mem_state_t;

    mem_state_t        state;
    logic [CNT_W-1:0]  cnt;
    logic              expire;

    bus_op_t           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;

    logic [DATA_W-1:0] mem [DEPTH];

    // ####################################################################
    // wait counter FSM
    // ####################################################################

    assign expire = (state == MEM_WAIT) && (cnt == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= MEM_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (bus.valid) begin
                        state <= MEM_WAIT;
                        cnt   <= CNT_W'(ACK_DELAY - 1);
                    end
                end

                MEM_WAIT: begin
                    if (cnt == '0) begin
                        state <= MEM_DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                // ack cycle, arbiter reloads on this edge.
                MEM_DONE: begin
                    state <= MEM_IDLE;
                end

                default: begin
                    state <= MEM_IDLE;
                end
            endcase
        end
    end

    // command latched at acceptance.
    always_ff @(posedge clk) begin
        if (state == MEM_IDLE && bus.valid) begin
            op_q    <= bus.op;
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
        end
    end

    // ####################################################################
    // storage
    // ####################################################################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (expire && op_q == OP_WRITE) begin
            mem[addr_q] <= wdata_q;
        end
    end

    // read data holds until the next read completes.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdata_q <= '0;
        end else if (expire && op_q == OP_READ) begin
            rdata_q <= mem[addr_q];
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ack   = (state == MEM_DONE);

endmodule

// File: hdl/bus_master_mux.sv
`timescale 1ns/10ps

module bus_master_mux #(
    parameter int N_MASTERS = bus_pkg::DEF_N_MASTERS,
    parameter int ADDR_W    = bus_pkg::DEF_ADDR_W,
    parameter int DATA_W    = bus_pkg::DEF_DATA_W
) (
    input  logic [N_MASTERS-1:0]        grant,
    input  logic [N_MASTERS-1:0]        write,
    input  logic [N_MASTERS*ADDR_W-1:0] addr_in,
    input  logic [N_MASTERS*DATA_W-1:0] wdata_in,
    output logic [N_MASTERS-1:0]        ack_out,
    output logic [DATA_W-1:0]           rdata_out,
    bus_if.mux_mp                       bus
);
    import bus_pkg::*;

    bus_op_t           sel_op;
    logic [ADDR_W-1:0] sel_addr;
    logic [DATA_W-1:0] sel_wdata;

    // ####################################################################
    // command select
    // ####################################################################

    // grant is one-hot or zero, so at most one slice is picked.
    always_comb begin
        sel_op    = OP_READ;
        sel_addr  = '0;
        sel_wdata = '0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (grant[i]) begin
                sel_op    = write[i] ? OP_WRITE : OP_READ;
                sel_addr  = addr_in[i*ADDR_W +: ADDR_W];
                sel_wdata = wdata_in[i*DATA_W +: DATA_W];
            end
        end
    end

    assign bus.valid = |grant;
    assign bus.op    = sel_op;
    assign bus.addr  = sel_addr;
    assign bus.wdata = sel_wdata;

    // ####################################################################
    // response steering
    // ####################################################################

    // ack goes back to the granted master only.
    assign ack_out = grant & {N_MASTERS{bus.ack}};

    // read data is shared by everyone.
    assign rdata_out = bus.rdata;

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter #(
    parameter int N_MASTERS = bus_pkg::DEF_N_MASTERS
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 bus_ack,
    input  logic [N_MASTERS-1:0] req,
    output logic [N_MASTERS-1:0] grant
);
    import bus_pkg::*;

    arb_state_t           state;
    logic [N_MASTERS-1:0] prio_grant;
    logic                 any_req;

    // ####################################################################
    // priority encoder
    // ####################################################################

    // lowest index wins, so scan downwards and let it overwrite.
    always_comb begin
        prio_grant = '0;
        for (int i = N_MASTERS - 1; i >= 0; i--) begin
            if (req[i]) begin
                prio_grant    = '0;
                prio_grant[i] = 1'b1;
            end
        end
    end

    assign any_req = |req;

    // ####################################################################
    // grant FSM
    // ####################################################################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ARB_READY;
            grant <= '0;
        end else begin
            case (state)
                ARB_READY: begin
                    // load on every edge while idle.
                    grant <= prio_grant;
                    if (any_req) begin
                        state <= ARB_BUSY;
                    end
                end

                ARB_BUSY: begin
                    // grant frozen until the slave acks.
                    if (bus_ack) begin
                        grant <= prio_grant;
                        if (!any_req) begin
                            state <= ARB_READY;
                        end
                    end
                end

                default: begin
                    state <= ARB_READY;
                    grant <= '0;
                end
            endcase
        end
    end

endmodule

// File: hdl/bus_if.sv
`timescale 1ns/10ps

interface bus_if #(
    parameter int ADDR_W = bus_pkg::DEF_ADDR_W,
    parameter int DATA_W = bus_pkg::DEF_DATA_W
);
    import bus_pkg::*;

    // command, master side to memory.
    logic              valid;
    bus_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // response, memory to master side.
    logic [DATA_W-1:0] rdata;
    logic              ack;

    modport mux_mp (
        output valid,
        output op,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport mem_mp (
        input  valid,
        input  op,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

// File: hdl/bus_pkg.sv
package bus_pkg;

    // ####################################################################
    // default sizes
    // ####################################################################

    // number of masters sharing the bus.
    parameter int DEF_N_MASTERS = 3;

    // memory slave geometry.
    parameter int DEF_ADDR_W = 4;
    parameter int DEF_DATA_W = 8;

    // cycles from command acceptance to ack.
    parameter int DEF_ACK_DELAY = 2;

    // ####################################################################
    // enums
    // ####################################################################

    // arbiter FSM.
    typedef enum logic {
        ARB_READY,
        ARB_BUSY
    } arb_state_t;

    // bus command opcode.
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_t;

endpackage
